// ==== filelist.f ====
+incdir+hw
hw/mips_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/mips_cpu.sv
hw/avalon_ram.sv
hw/mips_system.sv
test/mips_system_tb.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu import mips_pkg::*; (
    input  alu_op_e     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] y
);

    logic signed_lt;
    logic unsigned_lt;

    assign signed_lt   = $signed(a) < $signed(b);
    assign unsigned_lt = a < b;

    always_comb begin
        unique case (op)
            ALU_ADD: begin
                y = a + b;   // no overflow trap, addu/addiu only
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_AND: begin
                y = a & b;
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_SLT: begin
                y = {31'd0, signed_lt};
            end
            ALU_SLTU: begin
                y = {31'd0, unsigned_lt};
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

// ==== hw/avalon_ram.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module avalon_ram import mips_pkg::*; #(
    parameter int WAIT_CYCLES = `RAM_WAIT_CYCLES
) (
    input  logic        clk,
    input  logic        rst_n,
    input  avalon_req_t avs_req,
    output logic        waitrequest,
    output logic [31:0] readdata,
    input  ram_load_t   load
);

    localparam int CNT_W = $clog2(WAIT_CYCLES + 2);

    logic [31:0]      mem [`RAM_WORDS];
    logic [CNT_W-1:0] wait_cnt;
    logic             req;
    logic [7:0]       word_idx;

    assign req      = avs_req.read || avs_req.write;
    assign word_idx = avs_req.address[9:2];

    // high for WAIT_CYCLES cycles of each request, then one access cycle
    assign waitrequest = req && (wait_cnt < CNT_W'(WAIT_CYCLES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (req && !waitrequest) begin
            wait_cnt <= '0;   // rearm after the transfer
        end else if (req) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // load port wins, only used with the cpu in reset
    always_ff @(posedge clk) begin
        if (load.valid) begin
            mem[load.addr] <= load.data;
        end else if (avs_req.write && !waitrequest) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (avs_req.byteenable[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= avs_req.writedata[lane*8 +: 8];
                end
            end
        end
    end

    // valid in the completing cycle
    assign readdata = mem[word_idx];

endmodule

// ==== hw/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// byte address of the first instruction fetch
`define MIPS_RESET_VECTOR 32'h0000_0004

// ram geometry, 32-bit words
`define RAM_WORDS 256

// waitrequest cycles before each transfer completes
`define RAM_WAIT_CYCLES 2

// register indices
`define REG_V0 5'd2     // result register checked at halt
`define REG_RA 5'd31    // return address

`endif

// ==== hw/mips_cpu.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_cpu import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    output avalon_req_t avm_req,
    input  logic        waitrequest,
    input  logic [31:0] readdata,
    output logic        active,
    output logic [31:0] register_v0
);

    cpu_state_e  state;
    logic        started;   // set on the first clock out of reset
    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] alu_q;     // alu result held for mem and wb
    logic [31:0] mdr;       // load data

    opcode_e     opcode;
    funct_e      funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] imm_sext;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        wb_en;

    alu_op_e     alu_op;
    logic        use_imm;
    logic        is_load;
    logic        is_store;
    logic        is_byte;
    logic        is_jr;
    logic        writes_rd;
    logic        writes_rt;

    // instruction fields
    assign opcode   = opcode_e'(ir[31:26]);
    assign funct    = funct_e'(ir[5:0]);
    assign rs       = ir[25:21];
    assign rt       = ir[20:16];
    assign rd       = ir[15:11];
    assign imm_sext = {{16{ir[15]}}, ir[15:0]};

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_byte   = 1'b0;
        is_jr     = 1'b0;
        writes_rd = 1'b0;
        writes_rt = 1'b0;
        unique case (opcode)
            OP_RTYPE: begin
                writes_rd = 1'b1;
                unique case (funct)
                    F_JR: begin
                        is_jr     = 1'b1;
                        writes_rd = 1'b0;
                    end
                    F_ADDU: alu_op = ALU_ADD;
                    F_SUBU: alu_op = ALU_SUB;
                    F_AND:  alu_op = ALU_AND;
                    F_OR:   alu_op = ALU_OR;
                    F_SLT:  alu_op = ALU_SLT;
                    F_SLTU: alu_op = ALU_SLTU;
                    default: writes_rd = 1'b0;   // unknown funct runs as a nop
                endcase
            end
            OP_ADDIU: begin
                use_imm   = 1'b1;
                writes_rt = 1'b1;
            end
            OP_LW: begin
                use_imm   = 1'b1;
                is_load   = 1'b1;
                writes_rt = 1'b1;
            end
            OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            OP_SB: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
                is_byte  = 1'b1;
            end
            default: ;
        endcase
    end

    assign alu_b   = use_imm ? imm_sext : rt_data;
    assign wb_addr = writes_rd ? rd : rt;
    assign wb_data = is_load ? mdr : alu_q;
    assign wb_en   = (state == S_WB) && (writes_rd || writes_rt);

    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs),
        .rt_addr (rt),
        .rd_addr (wb_addr),
        .wr_en   (wb_en),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0_data (register_v0)
    );

    alu u_alu (
        .op (alu_op),
        .a  (rs_data),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_FETCH;
            started <= 1'b0;
            pc      <= `MIPS_RESET_VECTOR;
        end else if (!started) begin
            started <= 1'b1;   // fetch request goes out from here
        end else begin
            unique case (state)
                S_FETCH: if (!waitrequest) state <= S_EXEC;
                S_EXEC: begin
                    pc <= pc + 32'd4;
                    if (is_jr) begin
                        pc    <= rs_data;   // no delay slot
                        state <= (rs_data == 32'd0) ? S_HALT : S_FETCH;
                    end else if (is_load || is_store) begin
                        state <= S_MEM;
                    end else if (writes_rd || writes_rt) begin
                        state <= S_WB;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                S_MEM: if (!waitrequest) state <= is_load ? S_WB : S_FETCH;
                S_WB:    state <= S_FETCH;
                S_HALT:  state <= S_HALT;
                default: state <= S_FETCH;
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (state == S_FETCH && avm_req.read && !waitrequest) begin
            ir <= readdata;
        end
        if (state == S_EXEC) begin
            alu_q <= alu_y;
        end
        if (state == S_MEM && avm_req.read && !waitrequest) begin
            mdr <= readdata;
        end
    end

    // avalon request, stable for the whole state
    always_comb begin
        avm_req = '0;
        if (state == S_FETCH) begin
            avm_req.address    = pc;
            avm_req.read       = started;
            avm_req.byteenable = 4'hF;
        end else if (state == S_MEM) begin
            avm_req.address = alu_q;
            avm_req.read    = is_load;
            avm_req.write   = is_store;
            if (is_byte) begin
                avm_req.writedata  = {4{rt_data[7:0]}};   // byte on every lane
                avm_req.byteenable = 4'b0001 << alu_q[1:0];
            end else begin
                avm_req.writedata  = rt_data;
                avm_req.byteenable = 4'hF;
            end
        end
    end

    assign active = started && (state != S_HALT);

endmodule

// ==== hw/mips_pkg.sv ====
package mips_pkg;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDIU = 6'h09,
        OP_SB    = 6'h28,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // r-type function field, bits 5:0
    typedef enum logic [5:0] {
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2A,
        F_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALT
    } cpu_state_e;

    // avalon master request, held stable while waitrequest is high
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
        logic [3:0]  byteenable;
    } avalon_req_t;

    // program load word, whole-word write
    typedef struct packed {
        logic        valid;
        logic [7:0]  addr;   // word index
        logic [31:0] data;
    } ram_load_t;

endpackage

// ==== hw/mips_system.sv ====
`timescale 1ns/1ps

module mips_system import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  ram_load_t   load,
    output logic        active,
    output logic [31:0] register_v0
);

    avalon_req_t avm_req;
    logic        waitrequest;
    logic [31:0] readdata;

    mips_cpu u_cpu (
        .clk         (clk),
        .rst_n       (rst_n),
        .avm_req     (avm_req),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_ram u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .avs_req     (avm_req),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .load        (load)
    );

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`include "mips_consts.svh"

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [4:0]  rd_addr,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd_addr != 5'd0) begin   // $zero stays zero
            regs[rd_addr] <= wr_data;
        end
    end

    // asynchronous reads
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // debug tap for the result register
    assign v0_data = regs[`REG_V0];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module mips_system_tb \
    -Mdir obj_dir -o mips_system_sim > build.log 2>&1 \
    && ./obj_dir/mips_system_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// ==== test/mips_system_tb.sv ====
`timescale 1ns/1ps

module mips_system_tb import mips_pkg::*; ();

    localparam int START_LIMIT = 10;     // cycles for active to rise
    localparam int HALT_LIMIT  = 2000;   // cycles for active to fall

    logic            clk;
    logic            rst_n;
    ram_load_t       load;
    logic            active;
    logic [31:0]     register_v0;

    int              fd;
    int              rc;
    int              pass_count;
    int              fail_count;
    logic [7:0]      tag;
    logic [8*24-1:0] case_name;
    logic [8*128-1:0] skip_line;
    logic [7:0]      idx;
    logic [31:0]     word;
    logic [31:0]     expected_v0;
    logic [7:0]      load_idx [$];
    logic [31:0]     load_word [$];

    mips_system u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .active      (active),
        .register_v0 (register_v0)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // reset, load the buffered program, release and run to halt
    task automatic run_case();
        int          cycles;
        logic [31:0] v0_at_halt;
        rst_n = 1'b0;
        repeat (2) next_cycle();
        foreach (load_idx[i]) begin
            load.valid = 1'b1;
            load.addr  = load_idx[i];
            load.data  = load_word[i];
            next_cycle();
        end
        load  = '0;
        rst_n = 1'b1;
        cycles = 0;
        while (!active && cycles < START_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!active) begin
            $display("case %0s: CPU never started after reset", case_name);
            fail_count++;
            return;
        end
        cycles = 0;
        while (active && cycles < HALT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (active) begin
            $display("case %0s: CPU never halted within %0d cycles", case_name, HALT_LIMIT);
            fail_count++;
            return;
        end
        v0_at_halt = register_v0;
        repeat (3) next_cycle();   // halted cpu must leave v0 alone
        if (register_v0 !== v0_at_halt) begin
            $display("case %0s: v0 changed after the CPU halted", case_name);
            fail_count++;
        end else if (register_v0 !== expected_v0) begin
            $display("MISMATCH @%0t: case %0s v0 expected %h got %h",
                     $time, case_name, expected_v0, register_v0);
            fail_count++;
        end else begin
            $display("case %0s: ok, v0 = %h after %0d cycles", case_name, register_v0, cycles);
            pass_count++;
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        load       = '0;
        pass_count = 0;
        fail_count = 0;
        fd = $fopen("test/program_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open test/program_cases.txt");
            fail_count++;
        end else begin
            while ($fscanf(fd, " %s", tag) == 1) begin
                if (tag == "#") begin
                    rc = $fgets(skip_line, fd);   // comment line
                end else if (tag == "C") begin
                    rc = $fscanf(fd, " %s", case_name);
                    load_idx.delete();
                    load_word.delete();
                    if (rc != 1) begin
                        $display("case line without a name in the cases file");
                        fail_count++;
                    end
                end else if (tag == "L") begin
                    rc = $fscanf(fd, " %h %h", idx, word);
                    if (rc != 2) begin
                        $display("load line in case %0s lacks index or word", case_name);
                        fail_count++;
                    end else begin
                        load_idx.push_back(idx);
                        load_word.push_back(word);
                    end
                end else if (tag == "E") begin
                    rc = $fscanf(fd, " %h", expected_v0);
                    if (rc != 1) begin
                        $display("expected line in case %0s has no value", case_name);
                        fail_count++;
                    end
                end else if (tag == "X") begin
                    run_case();
                end else begin
                    $display("unknown line tag %c in the cases file", tag);
                    fail_count++;
                end
            end
            $fclose(fd);
        end
        $display("cases passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== test/program_cases.txt ====
# C name | L word_index(hex) instruction(hex) | E expected_v0(hex) | X run the case
# code starts at word 1 (reset vector 0x4), every case halts with jr $0
C addiu_slt
L 01 24080005
L 02 24090003
L 03 0109102A
L 04 00000008
E 00000000
X
C slt_reversed
L 01 24080005
L 02 24090003
L 03 0128102A
L 04 00000008
E 00000001
X
C addu
L 01 24081234
L 02 24090111
L 03 01091021
L 04 00000008
E 00001345
X
C subu
L 01 24081234
L 02 24090111
L 03 01091023
L 04 00000008
E 00001123
X
# v0 = 2*slt + sltu with t0 = -1 and t1 = 1
C slt_sltu_negative
L 01 2408FFFF
L 02 24090001
L 03 0109502A
L 04 0109582B
L 05 014A1021
L 06 004B1021
L 07 00000008
E 00000002
X
C and_loaded
L 40 F0F0FF00
L 41 0FF0F0F0
L 01 8C080100
L 02 8C090104
L 03 01091024
L 04 00000008
E 00F0F000
X
C or_loaded
L 40 F0F0FF00
L 41 0FF0F0F0
L 01 8C080100
L 02 8C090104
L 03 01091025
L 04 00000008
E FFF0FFF0
X
C sw_lw
L 01 2408EDCB
L 02 AC080080
L 03 8C020080
L 04 00000008
E FFFFEDCB
X
C sb_lw
L 30 11223344
L 01 240800AB
L 02 A00800C1
L 03 8C0200C0
L 04 00000008
E 1122AB44
X
